//--- verilog/montPkg.sv
`default_nettype none

package montPkg;

    // control FSM states, sequenced by montCtrl
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ITERATE,
        RESOLVE,
        SUBTRACT,
        FINISH
    } ctrlState_t;

    // segmented adder opcodes
    typedef enum logic [1:0] {
        ADD_IDLE,    // hold
        ADD_RESOLVE, // sum plus carry
        ADD_SUBMOD,  // resolved minus modulus
        ADD_PRESUM   // opB plus modulus, during load
    } addMode_t;

endpackage

`default_nettype wire

//--- verilog/addendSelect.sv
`default_nettype none

module addendSelect #(
    parameter int WIDTH = 64,
    parameter int SEG = 16,
    localparam int NSEG = WIDTH / SEG,
    localparam int SEGW = (NSEG > 1) ? $clog2(NSEG) : 1
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             loadEn,
    input  logic [WIDTH-1:0] opB,
    input  logic [WIDTH-1:0] modulus,
    input  logic             presumEn,
    input  logic [SEG:0]     presumSeg,
    input  logic [SEGW-1:0]  segIdx,
    input  logic             aBit,
    input  logic             parity,
    output logic [WIDTH:0]   addend,
    output logic [WIDTH-1:0] opBHeld,
    output logic [WIDTH-1:0] modHeld
);

    logic [WIDTH:0] presum; // opB + modulus needs one extra bit
    logic           quotient;

    // operands are held for the whole product, later starts do not touch them
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            opBHeld <= '0;
            modHeld <= '0;
        end
        else if (loadEn)
        begin
            opBHeld <= opB;
            modHeld <= modulus;
        end
    end

    always_ff @(posedge clk)
    begin
        if (presumEn)
        begin
            presum[segIdx*SEG +: SEG] <= presumSeg[SEG-1:0];
            if (segIdx == SEGW'(NSEG - 1))
                presum[WIDTH] <= presumSeg[SEG]; // carry out of the top segment
        end
    end

    // quotient bit makes the accumulator even after this addend
    assign quotient = parity ^ (aBit & opBHeld[0]);

    always_comb
    begin
        case ({aBit, quotient})
            2'b00:   addend = '0;
            2'b10:   addend = {1'b0, opBHeld};
            2'b01:   addend = {1'b0, modHeld};
            default: addend = presum;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/csaAccum.sv
`default_nettype none

module csaAccum #(
    parameter int WIDTH = 64
) (
    input  logic           clk,
    input  logic           resetn,
    input  logic           clearEn,
    input  logic           iterEn,
    input  logic [WIDTH:0] addend,
    output logic [WIDTH:0] sumVec,
    output logic [WIDTH:0] carryVec,
    output logic           parity
);

    logic [WIDTH:0] sumReg;
    logic [WIDTH:0] carryReg;
    logic [WIDTH:0] csaSum;   // weight 2^i
    logic [WIDTH:0] csaCarry; // weight 2^(i+1)

    // one full-adder cell per bit, no carry ripple between them
    genvar i;
    generate
        for (i = 0; i <= WIDTH; i = i + 1)
        begin : gBit
            assign csaSum[i]   = sumReg[i] ^ carryReg[i] ^ addend[i];
            assign csaCarry[i] = (sumReg[i] & carryReg[i]) |
                                 (sumReg[i] & addend[i]) |
                                 (carryReg[i] & addend[i]);
        end
    endgenerate

    // halving the pair: sum drops its low bit, carry loses its implicit x2
    always_ff @(posedge clk)
    begin
        if (!resetn || clearEn)
        begin
            sumReg   <= '0;
            carryReg <= '0;
        end
        else if (iterEn)
        begin
            sumReg   <= {1'b0, csaSum[WIDTH:1]};
            carryReg <= csaCarry;
        end
    end

    assign sumVec   = sumReg;
    assign carryVec = carryReg;

    // low bit of sum + carry, decides whether the modulus gets added
    assign parity = sumReg[0] ^ carryReg[0];

    // the quotient from addendSelect must leave the pair even
    evenBeforeShift: assert property (
        @(posedge clk) disable iff (!resetn)
        iterEn |-> !csaSum[0]
    ) else $error("csaAccum: odd value shifted out during iteration");

endmodule

`default_nettype wire

//--- verilog/segAdder.sv
`default_nettype none

module segAdder
    import montPkg::*;
#(
    parameter int WIDTH = 64,
    parameter int SEG = 16,
    localparam int NSEG = WIDTH / SEG,
    localparam int SEGW = (NSEG > 1) ? $clog2(NSEG) : 1
) (
    input  logic             clk,
    input  logic             resetn,
    input  addMode_t         addMode,
    input  logic [SEGW-1:0]  segIdx,
    input  logic [WIDTH:0]   sumVec,
    input  logic [WIDTH:0]   carryVec,
    input  logic [WIDTH-1:0] opB,
    input  logic [WIDTH-1:0] modulus,
    output logic [SEG:0]     presumSeg,
    output logic [WIDTH-1:0] result
);

    logic [SEG-1:0]   segA;
    logic [SEG-1:0]   segB;
    logic [SEG:0]     segSum;
    logic             carryIn;
    logic             carryReg; // carry between segments
    logic             segLast;
    logic [WIDTH-1:0] resolved;
    logic             resTop;   // bit WIDTH of the resolved value
    logic [WIDTH-1:0] diffReg;
    logic [WIDTH-1:0] diffNext;
    logic             keepDiff;

    always_comb
    begin
        segA = '0;
        segB = '0;
        case (addMode)
            ADD_RESOLVE:
            begin
                segA = sumVec[segIdx*SEG +: SEG];
                segB = carryVec[segIdx*SEG +: SEG];
            end
            ADD_SUBMOD:
            begin
                segA = resolved[segIdx*SEG +: SEG];
                segB = ~modulus[segIdx*SEG +: SEG]; // two's complement with carryIn
            end
            ADD_PRESUM:
            begin
                segA = opB[segIdx*SEG +: SEG];
                segB = modulus[segIdx*SEG +: SEG];
            end
            default: ;
        endcase
    end

    // first segment gets the initial carry, the rest the registered one
    assign carryIn = (segIdx == '0) ? (addMode == ADD_SUBMOD) : carryReg;
    assign segSum  = {1'b0, segA} + {1'b0, segB} + (SEG+1)'(carryIn);
    assign presumSeg = segSum;
    assign segLast = (segIdx == SEGW'(NSEG - 1));

    always_comb
    begin
        diffNext = diffReg;
        diffNext[segIdx*SEG +: SEG] = segSum[SEG-1:0];
    end

    // no borrow out of the full WIDTH+1 bit subtraction
    assign keepDiff = resTop | segSum[SEG];

    always_ff @(posedge clk)
    begin
        if (addMode == ADD_RESOLVE)
            resolved[segIdx*SEG +: SEG] <= segSum[SEG-1:0];
        if (addMode == ADD_SUBMOD)
            diffReg[segIdx*SEG +: SEG] <= segSum[SEG-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            carryReg <= 1'b0;
            resTop   <= 1'b0;
            result   <= '0;
        end
        else
        begin
            if (addMode != ADD_IDLE)
                carryReg <= segSum[SEG];
            if (addMode == ADD_RESOLVE && segLast)
                resTop <= sumVec[WIDTH] ^ carryVec[WIDTH] ^ segSum[SEG];
            if (addMode == ADD_SUBMOD && segLast)
                result <= keepDiff ? diffNext : resolved;
        end
    end

    segIdxRange: assert property (
        @(posedge clk) disable iff (!resetn)
        (addMode != ADD_IDLE) |-> (int'(segIdx) < NSEG)
    ) else $error("segAdder: segment index out of range");

    // subtraction only ever starts right after a full resolve pass
    subAfterResolve: assert property (
        @(posedge clk) disable iff (!resetn)
        (addMode == ADD_SUBMOD && segIdx == '0) |-> $past(addMode) == ADD_RESOLVE
    ) else $error("segAdder: subtract without resolve");

endmodule

`default_nettype wire

//--- verilog/montCtrl.sv
`default_nettype none

module montCtrl
    import montPkg::*;
#(
    parameter int WIDTH = 64,
    parameter int SEG = 16,
    localparam int NSEG = WIDTH / SEG,
    localparam int SEGW = (NSEG > 1) ? $clog2(NSEG) : 1,
    localparam int ITW = $clog2(WIDTH)
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  logic [WIDTH-1:0] opA,
    output logic             busy,
    output logic             done,
    output logic             aBit,
    output logic             loadEn,
    output logic             clearEn,
    output logic             iterEn,
    output logic             presumEn,
    output logic [SEGW-1:0]  segIdx,
    output addMode_t         addMode
);

    ctrlState_t       state;
    logic [SEGW-1:0]  segCnt;
    logic [ITW-1:0]   iterCnt;
    logic [WIDTH-1:0] aShift; // opA shifted right one bit per iteration
    logic             segLast;
    logic             iterLast;
    logic             segPhase;

    assign segLast  = (segCnt == SEGW'(NSEG - 1));
    assign iterLast = (iterCnt == ITW'(WIDTH - 1));
    assign segPhase = (state == LOAD) || (state == RESOLVE) || (state == SUBTRACT);

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state   <= IDLE;
            segCnt  <= '0;
            iterCnt <= '0;
        end
        else
        begin
            case (state)
                IDLE:     if (start) state <= LOAD;
                LOAD:     if (segLast) state <= ITERATE;
                ITERATE:  if (iterLast) state <= RESOLVE;
                RESOLVE:  if (segLast) state <= SUBTRACT;
                SUBTRACT: if (segLast) state <= FINISH;
                FINISH:   state <= IDLE;
                default:  state <= IDLE;
            endcase
            if (segPhase)
                segCnt <= segLast ? '0 : segCnt + 1'b1;
            if (iterEn)
                iterCnt <= iterLast ? '0 : iterCnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (loadEn)
            aShift <= opA;
        else if (iterEn)
            aShift <= aShift >> 1;
    end

    assign aBit     = aShift[0];
    assign busy     = (state != IDLE);
    assign done     = (state == FINISH);
    assign loadEn   = start && (state == IDLE); // start is ignored while busy
    assign clearEn  = (state == LOAD) && segLast; // accumulator empty before iterating
    assign iterEn   = (state == ITERATE);
    assign presumEn = (state == LOAD);
    assign segIdx   = segCnt;

    always_comb
    begin
        case (state)
            LOAD:     addMode = ADD_PRESUM;
            RESOLVE:  addMode = ADD_RESOLVE;
            SUBTRACT: addMode = ADD_SUBMOD;
            default:  addMode = ADD_IDLE;
        endcase
    end

    // every opA bit is shifted out by the time done rises
    allBitsConsumed: assert property (
        @(posedge clk) disable iff (!resetn)
        done |-> (aShift == '0)
    ) else $error("montCtrl: done before all opA bits were consumed");

endmodule

`default_nettype wire

//--- verilog/montMul.sv
`default_nettype none

module montMul
    import montPkg::*;
#(
    parameter int WIDTH = 64,
    parameter int SEG = 16,
    localparam int NSEG = WIDTH / SEG,
    localparam int SEGW = (NSEG > 1) ? $clog2(NSEG) : 1
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  logic [WIDTH-1:0] opA,
    input  logic [WIDTH-1:0] opB,
    input  logic [WIDTH-1:0] modulus,
    output logic [WIDTH-1:0] result,
    output logic             busy,
    output logic             done
);

    logic             aBit;
    logic             loadEn;
    logic             clearEn;
    logic             iterEn;
    logic             presumEn;
    logic [SEGW-1:0]  segIdx;
    addMode_t         addMode;
    logic [SEG:0]     presumSeg;
    logic [WIDTH:0]   addend;
    logic [WIDTH-1:0] opBHeld;  // latched at start
    logic [WIDTH-1:0] modHeld;
    logic [WIDTH:0]   sumVec;
    logic [WIDTH:0]   carryVec;
    logic             parity;

    montCtrl #(
        .WIDTH(WIDTH),
        .SEG(SEG)
    ) ctrl0 (
        .clk(clk),
        .resetn(resetn),
        .start(start),
        .opA(opA),
        .busy(busy),
        .done(done),
        .aBit(aBit),
        .loadEn(loadEn),
        .clearEn(clearEn),
        .iterEn(iterEn),
        .presumEn(presumEn),
        .segIdx(segIdx),
        .addMode(addMode)
    );

    addendSelect #(
        .WIDTH(WIDTH),
        .SEG(SEG)
    ) sel0 (
        .clk(clk),
        .resetn(resetn),
        .loadEn(loadEn),
        .opB(opB),
        .modulus(modulus),
        .presumEn(presumEn),
        .presumSeg(presumSeg),
        .segIdx(segIdx),
        .aBit(aBit),
        .parity(parity),
        .addend(addend),
        .opBHeld(opBHeld),
        .modHeld(modHeld)
    );

    csaAccum #(
        .WIDTH(WIDTH)
    ) acc0 (
        .clk(clk),
        .resetn(resetn),
        .clearEn(clearEn),
        .iterEn(iterEn),
        .addend(addend),
        .sumVec(sumVec),
        .carryVec(carryVec),
        .parity(parity)
    );

    segAdder #(
        .WIDTH(WIDTH),
        .SEG(SEG)
    ) add0 (
        .clk(clk),
        .resetn(resetn),
        .addMode(addMode),
        .segIdx(segIdx),
        .sumVec(sumVec),
        .carryVec(carryVec),
        .opB(opBHeld),
        .modulus(modHeld),
        .presumSeg(presumSeg),
        .result(result)
    );

endmodule

`default_nettype wire

//--- verif/montMulTb.sv
`default_nettype none

module montMulTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WIDTH = 64;
    localparam int SEG = 16;
    localparam int doneLatency = WIDTH + 3 * (WIDTH / SEG) + 1; // start sample to done
    localparam int timeoutCycles = 200;

    logic             clk;
    logic             resetn;
    logic             start;
    logic [WIDTH-1:0] opA;
    logic [WIDTH-1:0] opB;
    logic [WIDTH-1:0] modulus;
    logic [WIDTH-1:0] result;
    logic             busy;
    logic             done;

    int errorCount = 0;
    int testCount = 0;
    int passCount = 0;
    bit timedOut = 1'b0;
    int seed = 23;

    montMul #(
        .WIDTH(WIDTH),
        .SEG(SEG)
    ) dut0 (
        .clk(clk),
        .resetn(resetn),
        .start(start),
        .opA(opA),
        .opB(opB),
        .modulus(modulus),
        .result(result),
        .busy(busy),
        .done(done)
    );

    always #4 clk = ~clk;

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("error %s: got 0x%h, expected 0x%h", name, actual, expected);
            errorCount++;
        end
    endtask

    // core must stay quiet between products
    task automatic idleGap(input int cycles);
        for (int k = 0; k < cycles; k++)
        begin
            @(negedge clk);
            checkValue("busy", 64'(busy), 64'd0);
            checkValue("done", 64'(done), 64'd0);
        end
    endtask

    task automatic runProduct(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                              input logic [WIDTH-1:0] m, input logic [WIDTH-1:0] expected,
                              input bit interrupt);
        int cycles;
        int errorsBefore;
        errorsBefore = errorCount;
        opA = a;
        opB = b;
        modulus = m;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cycles = 1; // first negedge after the start sample
        while (done !== 1'b1 && cycles < timeoutCycles)
        begin
            checkValue("busy", 64'(busy), 64'd1);
            if (interrupt && cycles == 30)
            begin
                start = 1'b1; // stray start with other operands
                opA = ~a;
                opB = a;
                modulus = m ^ 64'h6;
            end
            else
                start = 1'b0;
            @(negedge clk);
            cycles++;
        end
        start = 1'b0;
        testCount++;
        if (done !== 1'b1)
        begin
            $display("test %0d: done did not arrive within %0d cycles", testCount, timeoutCycles);
            timedOut = 1'b1;
            errorCount++;
        end
        else
        begin
            checkValue("doneCycle", 64'(cycles), 64'(doneLatency));
            checkValue("busy", 64'(busy), 64'd1);
            checkValue("result", result, expected);
            @(negedge clk);
            checkValue("done", 64'(done), 64'd0); // one cycle pulse only
            checkValue("busy", 64'(busy), 64'd0);
            checkValue("result", result, expected);
            if (errorCount == errorsBefore)
            begin
                passCount++;
                $display("test %0d: ok, result 0x%h", testCount, result);
            end
            else
                $display("test %0d: failed", testCount);
        end
    endtask

    initial
    begin
        int fd;
        int fields;
        string line;
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] m;
        logic [WIDTH-1:0] expected;
        clk = 1'b0;
        resetn = 1'b0;
        start = 1'b0;
        opA = '0;
        opB = '0;
        modulus = '0;
        repeat (2) @(negedge clk);
        resetn = 1'b1;

        // state straight out of reset
        checkValue("busy", 64'(busy), 64'd0);
        checkValue("done", 64'(done), 64'd0);
        checkValue("result", result, 64'd0);

        fd = $fopen("verif/montTrace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file verif/montTrace.txt");
            errorCount++;
        end
        else
        begin
            while (!$feof(fd) && !timedOut)
            begin
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.substr(0, 0) != "#")
                begin
                    fields = $sscanf(line, "%h %h %h %h", a, b, m, expected);
                    if (fields != 4)
                    begin
                        $display("trace line could not be parsed: %s", line);
                        errorCount++;
                    end
                    else
                    begin
                        idleGap({$random(seed)} % 6);
                        runProduct(a, b, m, expected, (testCount % 3) == 1);
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d tests run, %0d passed, %0d errors", testCount, passCount, errorCount);
        if (errorCount == 0 && testCount > 0 && !timedOut)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/montTrace.txt
# columns: opA opB modulus expected, all hex
# expected = opA * opB * 2^-64 mod modulus
0000000000000003 0000000000000005 FFFFFFFFFFFFFFFF 000000000000000F
0000000000000001 FEDCBA9876543210 FFFFFFFFFFFFFFFF FEDCBA9876543210
FFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFF 0000000000000001
FFFFFFFFFFFFFFFE 0000000000000002 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFD
0000000000000000 123456789ABCDEF0 FFFFFFFFFFFFFFFF 0000000000000000
0000000100000000 0000000100000000 FFFFFFFFFFFFFFFF 0000000000000001
0000000000000001 0000000000000001 8000000000000001 4000000000000000
0000000000000002 0000000000000001 8000000000000001 8000000000000000
0000000000000002 0000000000000002 8000000000000001 7FFFFFFFFFFFFFFF
7FFFFFFFFFFFFFFF 123456789ABCDEF0 8000000000000001 123456789ABCDEF0
000000000000003B 0123456789ABCDEF FFFFFFFFFFFFFFC5 0123456789ABCDEF
0000000000000001 000000000000003B FFFFFFFFFFFFFFC5 0000000000000001
000000000000003B 000000000000003B FFFFFFFFFFFFFFC5 000000000000003B
0000000000000002 0000000000000002 0000000000000003 0000000000000001
0000000000000002 0000000000000001 0000000000000003 0000000000000002
5555555555555555 0000000000000000 FFFFFFFFFFFFFFC5 0000000000000000

//--- all.f
verilog/montPkg.sv
verilog/addendSelect.sv
verilog/csaAccum.sv
verilog/segAdder.sv
verilog/montCtrl.sv
verilog/montMul.sv
verif/montMulTb.sv

//--- Makefile
TOP = montMulTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP) -Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee sim.log
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
